//--- include/crossing_defs.svh
`ifndef CROSSING_DEFS_SVH
`define CROSSING_DEFS_SVH

// Playfield, 160 by 120 pixels
`define GRID_W          160
`define GRID_H          120
`define COORD_W         8

// Start positions
`define PLAYER_X0       2
`define PLAYER_Y0       112
`define CAR_X0          47
`define CAR_Y0          42

// Reaching this row scores a point
`define GOAL_Y          3

// 3-bit RGB colours
`define COLOUR_BG       0
`define COLOUR_PLAYER   4       // Red
`define COLOUR_CAR      6       // Red and green

// Clock cycles per sprite step
`define PLAYER_PERIOD   24
`define CAR_PERIOD      10

// Two decimal digits
`define SCORE_MAX       99

`endif

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_crossing -o tb_crossing \
    && ./obj_dir/tb_crossing > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || exit 1
exit 0

//--- src.f
+incdir+include
verilog/crossing_pkg.sv
verilog/step_timer.sv
verilog/sprite_mover.sv
verilog/collision_score.sv
verilog/pixel_merge.sv
verilog/score_display.sv
verilog/crossing_top.sv
test/tb_crossing.sv

//--- test/tb_crossing.sv
`include "crossing_defs.svh"

module tb_crossing;

    timeunit 1ns;
    timeprecision 1ps;

    import crossing_pkg::*;

    localparam int EV_PLAYER = 0;
    localparam int EV_CAR = 1;
    localparam int EV_RESTART = 2;
    localparam int EV_READY = 3;     // Both sprites back at their start draws
    localparam move_req_t UP = '{up: 1'b1, down: 1'b0, left: 1'b0, right: 1'b0};

    logic         clk = 1'b0;
    logic         reset_n;
    move_req_t    move;
    pixel_write_t pixel;
    seg7_t        hex_tens;
    seg7_t        hex_ones;

    int unsigned rng_state = 59;
    int errors = 0;
    int checks = 0;
    int failed_tests = 0;
    int test_errors = 0;

    // Reference model rebuilt from the pixel port
    int pl_x;
    int pl_y;
    int car_x;
    int car_y;
    bit pl_erased;
    bit car_erased;
    bit pl_start;
    bit car_start;
    int model_score = 0;
    int restarts = 0;
    int pl_draws = 0;
    int pl_writes = 0;
    int car_draws = 0;
    int car_wraps = 0;

    crossing_top DUT (.clk(clk), .reset_n(reset_n), .move(move), .pixel(pixel),
                      .hex_tens(hex_tens), .hex_ones(hex_ones));

    always #4 clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    // Lit segments as gfedcba then inverted for the active-low digit
    function automatic seg7_t digit_pattern(input int digit);
        logic [6:0] lit;
        case (digit)
            0: lit = 7'b0111111;
            1: lit = 7'b0000110;
            2: lit = 7'b1011011;
            3: lit = 7'b1001111;
            4: lit = 7'b1100110;
            5: lit = 7'b1101101;
            6: lit = 7'b1111101;
            7: lit = 7'b0000111;
            8: lit = 7'b1111111;
            9: lit = 7'b1101111;
            default: lit = 7'b0000000;
        endcase
        return ~lit;
    endfunction

    task automatic check_value(input int actual, input int expected, input string msg);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("Mismatch at time %0t: %s, got %0d, expected %0d", $time, msg, actual,
                     expected);
        end
    endtask

    function automatic int event_count(input int sel);
        case (sel)
            EV_PLAYER:  return pl_draws;
            EV_CAR:     return car_draws;
            EV_RESTART: return restarts;
            default:    return (pl_start || car_start) ? 0 : 1;
        endcase
    endfunction

    // Goal beats crash and nothing counts while the sprites redraw
    task automatic detect_events();
        if (!pl_start && !car_start)
        begin
            if (pl_y == `GOAL_Y || (pl_x == car_x && pl_y == car_y))
            begin
                if (pl_y != `GOAL_Y)
                    model_score = 0;
                else if (model_score < `SCORE_MAX)
                    model_score++;
                restarts++;
                pl_start = 1'b1;
                car_start = 1'b1;
            end
        end
    endtask

    task automatic track_write(input pixel_write_t w);
        int dx;
        int dy;
        if (w.colour == colour_t'(`COLOUR_BG))
        begin
            check_value((w.x == pl_x && w.y == pl_y) || (w.x == car_x && w.y == car_y), 1,
                        "erase lands on a sprite position");
            if (w.x == pl_x && w.y == pl_y)
            begin
                pl_erased = 1'b1;
                pl_writes++;
            end
            if (w.x == car_x && w.y == car_y)
                car_erased = 1'b1;
        end
        else if (w.colour == colour_t'(`COLOUR_PLAYER))
        begin
            check_value(pl_erased, 1, "player draw follows its erase");
            dx = w.x - pl_x;
            dy = w.y - pl_y;
            if (pl_start)
            begin
                check_value(w.x, `PLAYER_X0, "player start column");
                check_value(w.y, `PLAYER_Y0, "player start row");
            end
            else
                check_value((dx < 0 ? -dx : dx) + (dy < 0 ? -dy : dy), 1, "player step size");
            pl_start = 1'b0;
            pl_erased = 1'b0;
            pl_x = w.x;
            pl_y = w.y;
            pl_draws++;
            pl_writes++;
            detect_events();
        end
        else if (w.colour == colour_t'(`COLOUR_CAR))
        begin
            check_value(car_erased, 1, "car draw follows its erase");
            check_value(w.y, `CAR_Y0, "car row");
            if (car_start && w.x == `CAR_X0)
                car_start = 1'b0;
            else
            begin
                check_value(w.x, (car_x + 1) % `GRID_W, "car moves one column right");
                if (w.x == 0)
                    car_wraps++;        // Left the last column
            end
            car_erased = 1'b0;
            car_x = w.x;
            car_y = w.y;
            car_draws++;
            detect_events();
        end
        else
            check_value(w.colour, `COLOUR_BG, "write colour");
    endtask

    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            check_value(pixel.valid, 0, "pixel valid during reset");
            pl_x = `PLAYER_X0;
            pl_y = `PLAYER_Y0;
            car_x = `CAR_X0;
            car_y = `CAR_Y0;
            pl_erased = 1'b1;           // Power-up draw has no erase
            car_erased = 1'b1;
            pl_start = 1'b1;
            car_start = 1'b1;
            model_score = 0;
        end
        else if (pixel.valid)
            track_write(pixel);
    end

    task automatic set_move(input move_req_t req);
        @(posedge clk);
        #1;
        move = req;
    endtask

    task automatic wait_events(input int sel, input int target, input int limit,
                               input string what, output bit ok);
        int cycles;
        cycles = 0;
        while (event_count(sel) < target && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (event_count(sel) >= target);
        if (!ok)
        begin
            errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    // Holds the player still until the car sits lo..hi columns to its right around the row
    task automatic wait_car_offset(input int lo, input int hi);
        int cycles;
        int offset;
        set_move('0);
        for (cycles = 0; cycles < 2 * `GRID_W * `CAR_PERIOD; cycles++)
        begin
            offset = (car_x - pl_x + `GRID_W) % `GRID_W;
            if (offset >= lo && offset <= hi)
                break;
            @(posedge clk);
        end
        if (cycles == 2 * `GRID_W * `CAR_PERIOD)
        begin
            errors++;
            $display("Timed out waiting for the car to reach a safe column");
        end
    endtask

    task automatic player_step(input move_req_t req, output bit moved);
        int ex;
        int ey;
        int count;
        bit ok;
        ex = pl_x;
        ey = pl_y;
        if (req.right)
            ex++;
        else if (req.left)
            ex--;
        else if (req.down)
            ey++;
        else if (req.up)
            ey--;
        moved = (ex >= 0 && ex < `GRID_W && ey >= 0 && ey < `GRID_H
                 && (ex != pl_x || ey != pl_y));
        set_move(req);
        if (moved)
        begin
            wait_events(EV_PLAYER, pl_draws + 1, 2 * `PLAYER_PERIOD + 8, "a player draw", ok);
            check_value(pl_x, ex, "player column after move");
            check_value(pl_y, ey, "player row after move");
            moved = ok;
        end
        else
        begin
            count = pl_writes;
            repeat (2 * `PLAYER_PERIOD) @(posedge clk);
            check_value(pl_writes, count, "player writes without a possible move");
        end
    endtask

    task automatic climb_to(input int row);
        bit moved;
        int steps;
        moved = 1'b1;
        steps = 0;
        while (pl_y > row && moved && steps < `GRID_H)
        begin
            if (pl_y == `CAR_Y0 + 1)
                wait_car_offset(1, 50);     // Cross just behind the car
            player_step(UP, moved);
            steps++;
        end
        if (pl_y > row && moved)
        begin
            errors++;
            $display("Player did not reach row %0d within %0d steps", row, `GRID_H);
        end
        set_move('0);
    endtask

    task automatic check_display(input int score);
        check_value(hex_tens, digit_pattern(score / 10), "tens digit");
        check_value(hex_ones, digit_pattern(score % 10), "ones digit");
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors)
            $display("%s: pass", name);
        else
        begin
            failed_tests++;
            $display("%s: FAIL with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial
    begin
        move_req_t req;
        int i;
        int s;
        int steps;
        int mark;
        int exp_score;
        bit ok;
        bit moved;
        reset_n = 1'b0;
        move = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        wait_events(EV_READY, 1, 10, "the start draws", ok);
        check_display(0);
        end_test("Test 1 reset");

        mark = pl_writes;
        wait_events(EV_CAR, car_draws + 120, 130 * `CAR_PERIOD, "car moves", ok);
        check_value(car_wraps > 0, 1, "car wraps at the last column");
        check_value(pl_writes, mark, "player writes with no request");
        end_test("Test 2 car travel");

        mark = restarts;
        for (i = 0; i < 40; i++)
        begin
            req = move_req_t'(4'(next_rand()));
            if (pl_y <= 100)
                req.up = 1'b0;          // Stay well below the car row
            steps = 1 + next_rand() % 3;
            for (s = 0; s < steps; s++)
            begin
                player_step(req, moved);
                if (!moved)
                    break;
            end
        end
        set_move('0);
        check_value(restarts, mark, "restarts during random moves");
        end_test("Test 3 random player moves");

        exp_score = 0;
        for (i = 0; i < 3; i++)
        begin
            mark = restarts;
            climb_to(`GOAL_Y);
            wait_events(EV_RESTART, mark + 1, 8, "the goal restart", ok);
            wait_events(EV_READY, 1, 20, "the redraw after a goal", ok);
            exp_score++;
            check_value(model_score, exp_score, "score after a goal");
            check_display(exp_score);
        end
        end_test("Test 4 goal");

        climb_to(`CAR_Y0 + 1);
        wait_car_offset(110, 150);
        mark = restarts;
        player_step(UP, moved);
        set_move('0);
        wait_events(EV_RESTART, mark + 1, `GRID_W * `CAR_PERIOD, "the crash", ok);
        wait_events(EV_READY, 1, 20, "the redraw after a crash", ok);
        check_value(model_score, 0, "score after a crash");
        check_display(0);
        end_test("Test 5 crash");

        wait_events(EV_CAR, car_draws + 2, 4 * `CAR_PERIOD, "car moves", ok);
        check_value(pl_erased, 0, "player erase left without a draw");
        end_test("Test 6 merge ordering");

        $display("Tests: 6, failed: %0d, checks: %0d, errors: %0d", failed_tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- verilog/collision_score.sv
`include "crossing_defs.svh"

module collision_score (
    input  logic                 clk,
    input  logic                 reset_n,
    input  crossing_pkg::pos_t   player_pos,
    input  crossing_pkg::pos_t   car_pos,
    output logic                 restart,
    output crossing_pkg::score_t score
);

    import crossing_pkg::*;

    localparam logic [1:0] HOLD_CYCLES = 2'd3;     // Sprites need this long to redraw
    localparam score_t     SCORE_TOP   = score_t'(`SCORE_MAX);

    logic [1:0] hold_cnt;
    logic       detect_en;
    logic       goal;
    logic       crash;

    assign detect_en = !restart && (hold_cnt == 2'd0);
    assign goal      = (player_pos.y == coord_t'(`GOAL_Y));
    assign crash     = (player_pos == car_pos);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            restart  <= 1'b0;
            score    <= '0;
            hold_cnt <= 2'd0;
        end
        else
        begin
            restart <= 1'b0;
            if (detect_en && goal)          // Goal wins over crash
            begin
                restart  <= 1'b1;
                hold_cnt <= HOLD_CYCLES;
                if (score != SCORE_TOP)
                    score <= score + 1'b1;
            end
            else if (detect_en && crash)
            begin
                restart  <= 1'b1;
                hold_cnt <= HOLD_CYCLES;
                score    <= '0;
            end
            else if (!restart && (hold_cnt != 2'd0))
            begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

endmodule

//--- verilog/crossing_pkg.sv
`include "crossing_defs.svh"

package crossing_pkg;

    // One grid coordinate
    typedef logic [`COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef logic [2:0] colour_t;   // R, G, B

    // Direction request levels
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } move_req_t;

    // One pixel write, valid for a single cycle
    typedef struct packed {
        logic    valid;
        coord_t  x;
        coord_t  y;
        colour_t colour;
    } pixel_write_t;

    typedef logic [6:0] score_t;

    // Active low segments, a in bit 0 through g in bit 6
    typedef logic [6:0] seg7_t;

endpackage

//--- verilog/crossing_top.sv
`include "crossing_defs.svh"

module crossing_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  crossing_pkg::move_req_t    move,
    output crossing_pkg::pixel_write_t pixel,
    output crossing_pkg::seg7_t        hex_tens,
    output crossing_pkg::seg7_t        hex_ones
);

    import crossing_pkg::*;

    // The car only ever drives right
    localparam move_req_t CAR_MOVE = '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b1};

    logic         player_step;
    logic         car_step;
    logic         restart;
    pos_t         player_pos;
    pos_t         car_pos;
    pixel_write_t player_wr;
    pixel_write_t car_wr;
    score_t       score;

    step_timer #(.PERIOD(`PLAYER_PERIOD)) player_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .step    (player_step)
    );

    step_timer #(.PERIOD(`CAR_PERIOD)) car_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .step    (car_step)
    );

    sprite_mover #(
        .START_X (`PLAYER_X0),
        .START_Y (`PLAYER_Y0),
        .COLOUR  (`COLOUR_PLAYER),
        .WRAP    (1'b0)         // Player stops at the edge
    ) player_mover (
        .clk     (clk),
        .reset_n (reset_n),
        .step    (player_step),
        .move    (move),
        .restart (restart),
        .pos     (player_pos),
        .wr      (player_wr)
    );

    sprite_mover #(
        .START_X (`CAR_X0),
        .START_Y (`CAR_Y0),
        .COLOUR  (`COLOUR_CAR),
        .WRAP    (1'b1)
    ) car_mover (
        .clk     (clk),
        .reset_n (reset_n),
        .step    (car_step),
        .move    (CAR_MOVE),
        .restart (restart),
        .pos     (car_pos),
        .wr      (car_wr)
    );

    collision_score scorer (
        .clk        (clk),
        .reset_n    (reset_n),
        .player_pos (player_pos),
        .car_pos    (car_pos),
        .restart    (restart),
        .score      (score)
    );

    pixel_merge merge (
        .clk       (clk),
        .reset_n   (reset_n),
        .player_wr (player_wr),
        .car_wr    (car_wr),
        .wr        (pixel)
    );

    score_display display (
        .score (score),
        .tens  (hex_tens),
        .ones  (hex_ones)
    );

endmodule

//--- verilog/pixel_merge.sv
module pixel_merge (
    input  logic                       clk,
    input  logic                       reset_n,
    input  crossing_pkg::pixel_write_t player_wr,
    input  crossing_pkg::pixel_write_t car_wr,
    output crossing_pkg::pixel_write_t wr
);

    import crossing_pkg::*;

    pixel_write_t queue [2];    // Entry 0 is the oldest
    logic [1:0]   count;
    logic         push;
    logic         pop;
    logic         wr_idx;

    // Car writes wait behind a player write or behind older car writes
    assign push   = car_wr.valid && (player_wr.valid || (count != 2'd0));
    assign pop    = !player_wr.valid && (count != 2'd0);
    assign wr_idx = pop ? (count == 2'd2) : (count == 2'd1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= 2'd0;
            wr    <= '0;
        end
        else
        begin
            count <= count + {1'b0, push} - {1'b0, pop};
            if (player_wr.valid)
                wr <= player_wr;
            else if (count != 2'd0)
                wr <= queue[0];
            else
                wr <= car_wr;   // Straight through, or idle
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            queue[0] <= queue[1];
        if (push)
            queue[wr_idx] <= car_wr;
    end

endmodule

//--- verilog/score_display.sv
module score_display (
    input  crossing_pkg::score_t score,
    output crossing_pkg::seg7_t  tens,
    output crossing_pkg::seg7_t  ones
);

    import crossing_pkg::*;

    logic [3:0] tens_digit;
    logic [3:0] ones_digit;

    function automatic seg7_t digit_to_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    digit_to_seg = 7'b1000000;
            4'd1:    digit_to_seg = 7'b1111001;
            4'd2:    digit_to_seg = 7'b0100100;
            4'd3:    digit_to_seg = 7'b0110000;
            4'd4:    digit_to_seg = 7'b0011001;
            4'd5:    digit_to_seg = 7'b0010010;
            4'd6:    digit_to_seg = 7'b0000010;
            4'd7:    digit_to_seg = 7'b1111000;
            4'd8:    digit_to_seg = 7'b0000000;
            4'd9:    digit_to_seg = 7'b0010000;
            default: digit_to_seg = 7'b1111111;     // Blank
        endcase
    endfunction

    // Decimal split of the score
    always_comb
    begin
        tens_digit = 4'(score / 7'd10);
        ones_digit = 4'(score % 7'd10);
    end

    assign tens = digit_to_seg(tens_digit);
    assign ones = digit_to_seg(ones_digit);

endmodule

//--- verilog/sprite_mover.sv
`include "crossing_defs.svh"

module sprite_mover #(
    parameter crossing_pkg::coord_t  START_X = 8'd0,
    parameter crossing_pkg::coord_t  START_Y = 8'd0,
    parameter crossing_pkg::colour_t COLOUR  = 3'd7,
    parameter bit                    WRAP    = 1'b0
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       step,
    input  crossing_pkg::move_req_t    move,
    input  logic                       restart,
    output crossing_pkg::pos_t         pos,
    output crossing_pkg::pixel_write_t wr
);

    import crossing_pkg::*;

    typedef enum logic [2:0] {
        S_START_DRAW,
        S_IDLE,
        S_ERASE,
        S_DRAW,
        S_RESTART_ERASE
    } state_t;

    typedef enum logic [1:0] {
        DIR_RIGHT,
        DIR_LEFT,
        DIR_DOWN,
        DIR_UP
    } dir_t;

    localparam coord_t X_LAST    = coord_t'(`GRID_W - 1);
    localparam coord_t Y_LAST    = coord_t'(`GRID_H - 1);
    localparam pos_t   START_POS = '{x: START_X, y: START_Y};

    state_t state;
    state_t next_state;
    dir_t   sel_dir;        // Direction asked for this cycle
    dir_t   dir_q;          // Direction of the move in progress
    logic   can_move;
    logic   want_move;
    pos_t   next_pos;

    // Right beats left beats down beats up
    always_comb
    begin
        if (move.right)
            sel_dir = DIR_RIGHT;
        else if (move.left)
            sel_dir = DIR_LEFT;
        else if (move.down)
            sel_dir = DIR_DOWN;
        else
            sel_dir = DIR_UP;
    end

    // Edge check for the chosen direction
    always_comb
    begin
        case (sel_dir)
            DIR_RIGHT: can_move = WRAP || (pos.x != X_LAST);
            DIR_LEFT:  can_move = (pos.x != '0);
            DIR_DOWN:  can_move = (pos.y != Y_LAST);
            default:   can_move = (pos.y != '0);
        endcase
    end

    assign want_move = (|move) && can_move;

    // Position after the latched move
    always_comb
    begin
        next_pos = pos;
        case (dir_q)
            DIR_RIGHT: next_pos.x = (pos.x == X_LAST) ? '0 : pos.x + 1'b1;
            DIR_LEFT:  next_pos.x = pos.x - 1'b1;
            DIR_DOWN:  next_pos.y = pos.y + 1'b1;
            default:   next_pos.y = pos.y - 1'b1;
        endcase
    end

    always_comb
    begin
        case (state)
            S_START_DRAW:    next_state = S_IDLE;
            S_IDLE:          next_state = (step && want_move) ? S_ERASE : S_IDLE;
            S_ERASE:         next_state = S_DRAW;
            S_DRAW:          next_state = S_IDLE;
            S_RESTART_ERASE: next_state = S_START_DRAW;
            default:         next_state = S_START_DRAW;
        endcase
        if (restart)
            next_state = S_RESTART_ERASE;   // Overrides any state
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= S_START_DRAW;
            pos   <= START_POS;
        end
        else
        begin
            state <= next_state;
            if (state == S_START_DRAW)
                pos <= START_POS;
            else if (state == S_DRAW)
                pos <= next_pos;            // Lands with the draw write
        end
    end

    // Holds the tick's direction through erase and draw
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE)
            dir_q <= sel_dir;
    end

    always_comb
    begin
        case (state)
            S_START_DRAW:
                wr = '{valid: 1'b1, x: START_X, y: START_Y, colour: COLOUR};
            S_ERASE, S_RESTART_ERASE:
                wr = '{valid: 1'b1, x: pos.x, y: pos.y, colour: colour_t'(`COLOUR_BG)};
            S_DRAW:
                wr = '{valid: 1'b1, x: next_pos.x, y: next_pos.y, colour: COLOUR};
            default:
                wr = '0;
        endcase
    end

endmodule

//--- verilog/step_timer.sv
module step_timer #(
    parameter int PERIOD = 10
) (
    input  logic clk,
    input  logic reset_n,
    output logic step
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= '0;
            step  <= 1'b0;
        end
        else if (count == CNT_W'(PERIOD - 1))
        begin
            count <= '0;
            step  <= 1'b1;      // One tick per period
        end
        else
        begin
            count <= count + 1'b1;
            step  <= 1'b0;
        end
    end

endmodule
